// ==== verilog/pri_icache_pkg.sv ====
/*
 * Shared geometry localparams of the instruction cache,
 * address field types and the controller state encoding
 */

package pri_icache_pkg;

   //////////////////////////////////////////////////
   // Geometry
   //////////////////////////////////////////////////

   localparam int FETCH_ADDR_WIDTH = 32;
   // One line holds exactly one fetch word
   localparam int FETCH_DATA_WIDTH = 128;
   localparam int NB_WAYS          = 4;
   localparam int CACHE_SIZE       = 4096;

   // Byte offset inside a line
   localparam int OFFSET_WIDTH     = $clog2(FETCH_DATA_WIDTH / 8);
   localparam int NB_SETS          = CACHE_SIZE / (NB_WAYS * FETCH_DATA_WIDTH / 8);
   localparam int SET_WIDTH        = $clog2(NB_SETS);
   localparam int SET_LSB          = OFFSET_WIDTH;
   // Full tag, everything above the set index
   localparam int TAG_LSB          = SET_LSB + SET_WIDTH;
   localparam int TAG_WIDTH        = FETCH_ADDR_WIDTH - TAG_LSB;

   //////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////

   typedef logic [FETCH_ADDR_WIDTH-1:0] fetch_addr_t;
   typedef logic [FETCH_DATA_WIDTH-1:0] line_data_t;
   typedef logic [SET_WIDTH-1:0]        set_idx_t;
   typedef logic [TAG_WIDTH-1:0]        tag_t;
   typedef logic [NB_WAYS-1:0]          way_vec_t;
   typedef logic [$clog2(NB_WAYS)-1:0]  way_idx_t;

   // Controller states
   typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, BYPASS, FLUSH} ctrl_state_e;

endpackage

// ==== verilog/pri_icache_data_bank.sv ====
/*
 * Line data array of one way, synchronous read
 */

`timescale 1ns/1ps

module pri_icache_data_bank
   import pri_icache_pkg::*;
(
   input  logic       clk,
   input  logic       req_i,
   input  logic       we_i,
   input  set_idx_t   set_i,
   input  line_data_t wdata_i,
   output line_data_t rdata_o
);

   line_data_t line_mem [NB_SETS];

   // Write a line or register the addressed one
   always_ff @(posedge clk)
   begin
      if (req_i && we_i)
         line_mem[set_i] <= wdata_i;
      else if (req_i)
         rdata_o <= line_mem[set_i];
   end

endmodule

// ==== verilog/pri_icache_tag_bank.sv ====
/*
 * Tag array of one way with a flip-flop valid vector
 * and a single cycle clear of all valid bits
 */

`timescale 1ns/1ps

module pri_icache_tag_bank
   import pri_icache_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n_i,
   input  logic     req_i,
   input  logic     we_i,
   input  set_idx_t set_i,
   input  tag_t     wdata_i,
   input  logic     clear_i,
   output tag_t     rdata_o,
   output logic     valid_o
);

   tag_t               tag_mem [NB_SETS];
   logic [NB_SETS-1:0] valid_q;

   // Valid bits and their read register
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_q <= '0;
         valid_o <= 1'b0;
      end
      else
      begin
         if (clear_i)
            valid_q <= '0;
         else if (req_i && we_i)
            valid_q[set_i] <= 1'b1;
         if (req_i && !we_i)
            valid_o <= valid_q[set_i];
      end
   end

   // Tag storage, synchronous read
   always_ff @(posedge clk)
   begin
      if (req_i && we_i)
         tag_mem[set_i] <= wdata_i;
      else if (req_i)
         rdata_o <= tag_mem[set_i];
   end

endmodule

// ==== verilog/pri_icache_refill_port.sv ====
/*
 * Refill port, holds a request until granted
 * and registers the memory response
 */

`timescale 1ns/1ps

module pri_icache_refill_port
   import pri_icache_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        refill_start_i,
   input  fetch_addr_t refill_addr_i,
   input  logic        refill_gnt_i,
   input  logic        refill_r_valid_i,
   input  line_data_t  refill_r_data_i,
   output logic        refill_req_o,
   output fetch_addr_t refill_addr_o,
   output logic        refill_done_o,
   output line_data_t  refill_data_o
);

   logic        req_q;
   fetch_addr_t addr_q;
   logic        done_q;
   line_data_t  data_q;

   // Start goes out at once, the register keeps it up until the grant
   assign refill_req_o  = refill_start_i | req_q;
   assign refill_addr_o = req_q ? addr_q : refill_addr_i;

   // Response stage, always accepted
   assign refill_done_o = done_q;
   assign refill_data_o = data_q;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         req_q  <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         req_q  <= refill_req_o & ~refill_gnt_i;
         done_q <= refill_r_valid_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (refill_start_i)
         addr_q <= refill_addr_i;
      // Data stays until the next response
      if (refill_r_valid_i)
         data_q <= refill_r_data_i;
   end

endmodule

// ==== verilog/pri_icache_ctrl.sv ====
/*
 * Cache controller, lookup and refill FSM with hit compare,
 * round robin victim pointer, bypass and flush status
 */

`timescale 1ns/1ps

module pri_icache_ctrl
   import pri_icache_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     arst_n_i,

   // Processor side
   input  logic                     fetch_req_i,
   input  fetch_addr_t              fetch_addr_i,
   input  logic                     bypass_icache_i,
   input  logic                     flush_icache_i,

   // Refill port side
   input  logic                     refill_done_i,
   input  line_data_t               refill_data_i,

   // Bank read results
   input  tag_t [NB_WAYS-1:0]       tag_rdata_i,
   input  way_vec_t                 tag_valid_i,
   input  line_data_t [NB_WAYS-1:0] data_rdata_i,

   output logic                     fetch_gnt_o,
   output logic                     fetch_rvalid_o,
   output line_data_t               fetch_rdata_o,
   output logic                     refill_start_o,
   output fetch_addr_t              refill_addr_o,

   output way_vec_t                 tag_req_o,
   output way_vec_t                 tag_we_o,
   output set_idx_t                 tag_set_o,
   output tag_t                     tag_wdata_o,
   output logic                     tag_clear_o,
   output way_vec_t                 data_req_o,
   output logic                     data_we_o,
   output set_idx_t                 data_set_o,
   output line_data_t               data_wdata_o,

   output logic                     cache_is_bypassed_o,
   output logic                     cache_is_flushed_o
);

   ctrl_state_e state_q, state_d;

   // Registered fetch address, held for the whole transaction
   fetch_addr_t addr_q;
   way_idx_t    victim_q;
   logic        bypass_start_q;
   logic        reply_q;
   logic        flushed_q;

   way_vec_t    hit_way;
   way_vec_t    victim_vec;
   line_data_t  hit_data;
   logic        hit;
   logic        refill_write;
   set_idx_t    fetch_set;
   set_idx_t    addr_set;
   tag_t        addr_tag;

   assign fetch_set  = fetch_addr_i[SET_LSB +: SET_WIDTH];
   assign addr_set   = addr_q[SET_LSB +: SET_WIDTH];
   assign addr_tag   = addr_q[TAG_LSB +: TAG_WIDTH];
   assign victim_vec = way_vec_t'(1) << victim_q;

   // No grant while busy or while a flush is pending
   assign fetch_gnt_o  = fetch_req_i & (state_q == IDLE) & ~flush_icache_i;
   assign refill_write = (state_q == REFILL) & refill_done_i;
   assign tag_clear_o  = (state_q == IDLE) & flush_icache_i;

   //////////////////////////////////////////////////
   // Hit compare over all ways
   //////////////////////////////////////////////////

   always_comb
   begin
      hit_data = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         hit_way[w] = tag_valid_i[w] & (tag_rdata_i[w] == addr_tag);
         // At most one way matches, so an OR mux is enough
         if (hit_way[w])
            hit_data = hit_data | data_rdata_i[w];
      end
   end

   assign hit = |hit_way;

   // Hit answers in LOOKUP, refill and bypass answer one cycle after done
   assign fetch_rvalid_o = ((state_q == LOOKUP) & hit) | reply_q;
   assign fetch_rdata_o  = (state_q == LOOKUP) ? hit_data : refill_data_i;

   // Miss starts from LOOKUP, bypass one cycle after the grant
   assign refill_start_o = ((state_q == LOOKUP) & ~hit) | bypass_start_q;
   assign refill_addr_o  = {addr_q[FETCH_ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

   assign cache_is_bypassed_o = bypass_icache_i & ((state_q == IDLE) | (state_q == BYPASS));
   assign cache_is_flushed_o  = flushed_q;

   //////////////////////////////////////////////////
   // Bank requests
   //////////////////////////////////////////////////

   always_comb
   begin
      tag_req_o  = '0;
      tag_we_o   = '0;
      data_req_o = '0;
      data_we_o  = 1'b0;
      tag_set_o  = fetch_set;
      data_set_o = fetch_set;
      // Read every way at the set of a granted cached fetch
      if (fetch_gnt_o && !bypass_icache_i)
      begin
         tag_req_o  = '1;
         data_req_o = '1;
      end
      // Line allocation into the victim way
      if (refill_write)
      begin
         tag_req_o  = victim_vec;
         tag_we_o   = victim_vec;
         data_req_o = victim_vec;
         data_we_o  = 1'b1;
         tag_set_o  = addr_set;
         data_set_o = addr_set;
      end
   end

   assign tag_wdata_o  = addr_tag;
   assign data_wdata_o = refill_data_i;

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            // Flush wins over a fetch
            if (flush_icache_i)
               state_d = FLUSH;
            else if (fetch_gnt_o)
               state_d = bypass_icache_i ? BYPASS : LOOKUP;
         end
         LOOKUP:
            state_d = hit ? IDLE : REFILL;
         REFILL, BYPASS:
         begin
            if (reply_q)
               state_d = IDLE;
         end
         FLUSH:
         begin
            if (!flush_icache_i)
               state_d = IDLE;
         end
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q        <= IDLE;
         victim_q       <= '0;
         bypass_start_q <= 1'b0;
         reply_q        <= 1'b0;
         flushed_q      <= 1'b1;
      end
      else
      begin
         state_q        <= state_d;
         bypass_start_q <= fetch_gnt_o & bypass_icache_i;
         reply_q        <= refill_done_i & ((state_q == REFILL) | (state_q == BYPASS));
         // Round robin, advanced on every allocation
         if (refill_write)
            victim_q <= victim_q + 1'b1;
         if (tag_clear_o)
            flushed_q <= 1'b1;
         else if (refill_write)
            flushed_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (fetch_gnt_o)
         addr_q <= fetch_addr_i;
   end

endmodule

// ==== verilog/pri_icache.sv ====
/*
 * Instruction cache top level, four ways, one fetch port
 * Wires the controller, the refill port and the tag and data banks
 */

`timescale 1ns/1ps

module pri_icache
   import pri_icache_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n_i,

   // Processor fetch port
   input  logic        fetch_req_i,
   input  fetch_addr_t fetch_addr_i,
   output logic        fetch_gnt_o,
   output logic        fetch_rvalid_o,
   output line_data_t  fetch_rdata_o,

   // Memory refill port
   output logic        refill_req_o,
   input  logic        refill_gnt_i,
   output fetch_addr_t refill_addr_o,
   input  logic        refill_r_valid_i,
   input  line_data_t  refill_r_data_i,

   // Cache wide controls
   input  logic        bypass_icache_i,
   output logic        cache_is_bypassed_o,
   input  logic        flush_icache_i,
   output logic        cache_is_flushed_o
);

   // Controller to refill port
   logic        refill_start;
   fetch_addr_t refill_addr;
   logic        refill_done;
   line_data_t  refill_data;

   // Controller to tag banks
   way_vec_t             tag_req;
   way_vec_t             tag_we;
   set_idx_t             tag_set;
   tag_t                 tag_wdata;
   tag_t [NB_WAYS-1:0]   tag_rdata;
   way_vec_t             tag_valid;
   logic                 tag_clear;

   // Controller to data banks
   way_vec_t                 data_req;
   logic                     data_we;
   set_idx_t                 data_set;
   line_data_t               data_wdata;
   line_data_t [NB_WAYS-1:0] data_rdata;

   //////////////////////////////////////////////////
   // Controller and refill port
   //////////////////////////////////////////////////

   pri_icache_ctrl i_ctrl (
      .clk_i               ( clk                 ),
      .arst_n_i            ( arst_n_i            ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .flush_icache_i      ( flush_icache_i      ),
      .refill_done_i       ( refill_done         ),
      .refill_data_i       ( refill_data         ),
      .tag_rdata_i         ( tag_rdata           ),
      .tag_valid_i         ( tag_valid           ),
      .data_rdata_i        ( data_rdata          ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_start_o      ( refill_start        ),
      .refill_addr_o       ( refill_addr         ),
      .tag_req_o           ( tag_req             ),
      .tag_we_o            ( tag_we              ),
      .tag_set_o           ( tag_set             ),
      .tag_wdata_o         ( tag_wdata           ),
      .tag_clear_o         ( tag_clear           ),
      .data_req_o          ( data_req            ),
      .data_we_o           ( data_we             ),
      .data_set_o          ( data_set            ),
      .data_wdata_o        ( data_wdata          ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .cache_is_flushed_o  ( cache_is_flushed_o  )
   );

   pri_icache_refill_port i_refill_port (
      .clk              ( clk              ),
      .arst_n_i         ( arst_n_i         ),
      .refill_start_i   ( refill_start     ),
      .refill_addr_i    ( refill_addr      ),
      .refill_gnt_i     ( refill_gnt_i     ),
      .refill_r_valid_i ( refill_r_valid_i ),
      .refill_r_data_i  ( refill_r_data_i  ),
      .refill_req_o     ( refill_req_o     ),
      .refill_addr_o    ( refill_addr_o    ),
      .refill_done_o    ( refill_done      ),
      .refill_data_o    ( refill_data      )
   );

   //////////////////////////////////////////////////
   // Tag and data banks, one of each per way
   //////////////////////////////////////////////////

   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_tag_way
      pri_icache_tag_bank i_tag_bank (
         .clk      ( clk          ),
         .arst_n_i ( arst_n_i     ),
         .req_i    ( tag_req[w]   ),
         .we_i     ( tag_we[w]    ),
         .set_i    ( tag_set      ),
         .wdata_i  ( tag_wdata    ),
         .clear_i  ( tag_clear    ),
         .rdata_o  ( tag_rdata[w] ),
         .valid_o  ( tag_valid[w] )
      );
   end

   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_data_way
      pri_icache_data_bank i_data_bank (
         .clk     ( clk           ),
         .req_i   ( data_req[w]   ),
         .we_i    ( data_we       ),
         .set_i   ( data_set      ),
         .wdata_i ( data_wdata    ),
         .rdata_o ( data_rdata[w] )
      );
   end

endmodule

// ==== tests/pri_icache_properties.sv ====
/*
 * Concurrent assertions on the fetch and refill ports,
 * bound to the cache top level
 */

`timescale 1ns/1ps

module pri_icache_properties
   import pri_icache_pkg::*;
(
   input logic        clk,
   input logic        arst_n_i,
   input logic        fetch_req_i,
   input logic        fetch_gnt_i,
   input logic        fetch_rvalid_i,
   input logic        refill_req_i,
   input logic        refill_gnt_i,
   input fetch_addr_t refill_addr_i,
   input ctrl_state_e ctrl_state_i
);

   // Grant only answers a pending request
   a_gnt_with_req : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      fetch_gnt_i |-> fetch_req_i
   ) else $error("fetch grant without a fetch request");

   // Refill request and address stay put until granted
   a_refill_hold : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      (refill_req_i && !refill_gnt_i) |=> (refill_req_i && $stable(refill_addr_i))
   ) else $error("refill request or address changed before the grant");

   // Responses only leave a busy controller
   a_rvalid_busy : assert property (
      @(posedge clk) disable iff (!arst_n_i)
      fetch_rvalid_i |-> (ctrl_state_i != IDLE)
   ) else $error("fetch response while the controller is idle");

endmodule

bind pri_icache pri_icache_properties i_properties (
   .clk            ( clk            ),
   .arst_n_i       ( arst_n_i       ),
   .fetch_req_i    ( fetch_req_i    ),
   .fetch_gnt_i    ( fetch_gnt_o    ),
   .fetch_rvalid_i ( fetch_rvalid_o ),
   .refill_req_i   ( refill_req_o   ),
   .refill_gnt_i   ( refill_gnt_i   ),
   .refill_addr_i  ( refill_addr_o  ),
   .ctrl_state_i   ( i_ctrl.state_q )
);

// ==== tests/tb_pri_icache.sv ====
/*
 * Testbench of the instruction cache with clock, reset, memory model,
 * cache model and a stimulus table applied in a loop
 */

`timescale 1ns/1ps

module tb_pri_icache
   import pri_icache_pkg::*;
();

   typedef enum logic [1:0] {OP_FETCH, OP_FLUSH, OP_BYPASS_ON, OP_BYPASS_OFF} op_e;

   logic        clk;
   logic        arst_n_i;
   logic        fetch_req_i;
   fetch_addr_t fetch_addr_i;
   logic        fetch_gnt_o;
   logic        fetch_rvalid_o;
   line_data_t  fetch_rdata_o;
   logic        refill_req_o;
   logic        refill_gnt_i;
   fetch_addr_t refill_addr_o;
   logic        refill_r_valid_i;
   line_data_t  refill_r_data_i;
   logic        bypass_icache_i;
   logic        cache_is_bypassed_o;
   logic        flush_icache_i;
   logic        cache_is_flushed_o;

   // Stimulus table, one column per field
   op_e         op_table   [$];
   fetch_addr_t addr_table [$];
   logic        hit_table  [$];

   // Cache model state
   tag_t                model_tag   [NB_SETS][NB_WAYS];
   logic [NB_WAYS-1:0]  model_valid [NB_SETS];
   int                  model_rr;
   logic                model_flushed;
   logic                model_bypass;

   int          error_count = 0;
   int          refill_count = 0;
   int          max_wait = 200;
   bit          timed_out = 1'b0;
   fetch_addr_t last_refill_addr;

   pri_icache UUT (
      .clk                 ( clk                 ),
      .arst_n_i            ( arst_n_i            ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_r_valid_i    ( refill_r_valid_i    ),
      .refill_r_data_i     ( refill_r_data_i     ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  )
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Memory model
   //////////////////////////////////////////////////

   // Line address in every 32 bit lane, XORed with the lane number
   function automatic line_data_t line_pattern(input fetch_addr_t line_addr);
      line_data_t data;
      for (int lane = 0; lane < FETCH_DATA_WIDTH / 32; lane++)
         data[32*lane +: 32] = line_addr ^ lane;
      return data;
   endfunction

   initial
   begin : memory_model
      int          gnt_delay;
      int          rsp_delay;
      fetch_addr_t req_addr;
      void'($urandom(32'hef54));
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      forever
      begin
         @(negedge clk);
         if (arst_n_i && refill_req_o)
         begin
            req_addr         = refill_addr_o;
            last_refill_addr = req_addr;
            refill_count++;
            // Grant after a random wait
            gnt_delay = $urandom_range(3, 0);
            repeat (gnt_delay) @(posedge clk);
            @(posedge clk);
            #1 refill_gnt_i = 1'b1;
            @(posedge clk);
            #1 refill_gnt_i = 1'b0;
            // One response per grant
            rsp_delay = $urandom_range(4, 1);
            repeat (rsp_delay) @(posedge clk);
            #1;
            refill_r_valid_i = 1'b1;
            refill_r_data_i  = line_pattern(req_addr);
            @(posedge clk);
            #1 refill_r_valid_i = 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////
   // Cache model
   //////////////////////////////////////////////////

   task automatic reset_model();
      for (int s = 0; s < NB_SETS; s++)
         model_valid[s] = '0;
      model_rr      = 0;
      model_flushed = 1'b1;
      model_bypass  = 1'b0;
   endtask

   // Hit or miss, a miss outside bypass allocates the round robin way
   task automatic predict_fetch(input fetch_addr_t addr, output logic hit);
      int   set_idx;
      tag_t tag;
      set_idx = addr[SET_LSB +: SET_WIDTH];
      tag     = addr[TAG_LSB +: TAG_WIDTH];
      hit     = 1'b0;
      if (!model_bypass)
      begin
         for (int w = 0; w < NB_WAYS; w++)
            if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
               hit = 1'b1;
         if (!hit)
         begin
            model_tag[set_idx][model_rr]   = tag;
            model_valid[set_idx][model_rr] = 1'b1;
            model_rr      = (model_rr + 1) % NB_WAYS;
            model_flushed = 1'b0;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic add_entry(input op_e op, input fetch_addr_t addr, input logic hit);
      op_table.push_back(op);
      addr_table.push_back(addr);
      hit_table.push_back(hit);
   endtask

   task automatic build_table();
      // Miss, then a hit on the same line
      add_entry(OP_FETCH, 32'h0000_1230, 1'b0);
      add_entry(OP_FETCH, 32'h0000_1238, 1'b1);
      // Five lines in set 5, the last one evicts the first
      add_entry(OP_FETCH, 32'h0001_0050, 1'b0);
      add_entry(OP_FETCH, 32'h0001_0450, 1'b0);
      add_entry(OP_FETCH, 32'h0001_0850, 1'b0);
      add_entry(OP_FETCH, 32'h0001_0C50, 1'b0);
      add_entry(OP_FETCH, 32'h0001_1050, 1'b0);
      add_entry(OP_FETCH, 32'h0001_1054, 1'b1);
      add_entry(OP_FETCH, 32'h0001_0C58, 1'b1);
      add_entry(OP_FETCH, 32'h0001_085C, 1'b1);
      add_entry(OP_FETCH, 32'h0001_0450, 1'b1);
      add_entry(OP_FETCH, 32'h0001_0050, 1'b0);
      add_entry(OP_FETCH, 32'h0001_0450, 1'b0);
      add_entry(OP_FETCH, 32'h0000_1230, 1'b1);
      // Flush, cached lines miss again
      add_entry(OP_FLUSH, 32'h0, 1'b0);
      add_entry(OP_FETCH, 32'h0000_1230, 1'b0);
      add_entry(OP_FETCH, 32'h0001_0050, 1'b0);
      // Bypass always goes to memory
      add_entry(OP_BYPASS_ON, 32'h0, 1'b0);
      add_entry(OP_FETCH, 32'h0002_0770, 1'b0);
      add_entry(OP_FETCH, 32'h0002_0770, 1'b0);
      add_entry(OP_FETCH, 32'h0000_1230, 1'b0);
      add_entry(OP_BYPASS_OFF, 32'h0, 1'b0);
      // Nothing was allocated during bypass
      add_entry(OP_FETCH, 32'h0002_0770, 1'b0);
      add_entry(OP_FETCH, 32'h0002_0774, 1'b1);
      add_entry(OP_FETCH, 32'h0000_1230, 1'b1);
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("Error %s expected %h actual %h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic run_fetch(input fetch_addr_t addr, input logic exp_hit);
      int          wait_cycles;
      int          latency;
      int          exp_refills;
      fetch_addr_t line_addr;
      // Line address has the four byte offset bits cleared
      line_addr   = addr & 32'hFFFF_FFF0;
      exp_refills = refill_count + (exp_hit ? 0 : 1);
      @(posedge clk);
      #1;
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      // Request held until the grant cycle
      wait_cycles = 0;
      @(negedge clk);
      while (!fetch_gnt_o && wait_cycles < max_wait)
      begin
         @(negedge clk);
         wait_cycles++;
      end
      if (!fetch_gnt_o)
      begin
         $display("No fetch grant for address %h within %0d cycles", addr, max_wait);
         error_count++;
         timed_out = 1'b1;
         return;
      end
      @(posedge clk);
      #1 fetch_req_i = 1'b0;
      // Cycles from the grant to the response
      latency = 1;
      @(negedge clk);
      while (!fetch_rvalid_o && latency < max_wait)
      begin
         @(negedge clk);
         latency++;
      end
      if (!fetch_rvalid_o)
      begin
         $display("No fetch response for address %h within %0d cycles", addr, max_wait);
         error_count++;
         timed_out = 1'b1;
         return;
      end
      if (exp_hit && latency != 1)
      begin
         $display("Error fetch_rvalid_o latency expected %h actual %h", 1, latency);
         error_count++;
      end
      if (refill_count != exp_refills)
      begin
         $display("Error refill_req_o count expected %h actual %h", exp_refills, refill_count);
         error_count++;
      end
      if (!exp_hit && last_refill_addr !== line_addr)
      begin
         $display("Error refill_addr_o expected %h actual %h", line_addr, last_refill_addr);
         error_count++;
      end
      if (fetch_rdata_o !== line_pattern(line_addr))
      begin
         $display("Error fetch_rdata_o expected %h actual %h",
                  line_pattern(line_addr), fetch_rdata_o);
         error_count++;
      end
   endtask

   task automatic apply_entry(input int idx);
      logic model_hit;
      case (op_table[idx])
         OP_FETCH:
         begin
            predict_fetch(addr_table[idx], model_hit);
            if (model_hit !== hit_table[idx])
            begin
               $display("Cache model and table entry %0d disagree on hit or miss", idx);
               error_count++;
            end
            run_fetch(addr_table[idx], model_hit);
         end
         OP_FLUSH:
         begin
            reset_model_valid();
            @(posedge clk);
            #1 flush_icache_i = 1'b1;
            @(posedge clk);
            #1 flush_icache_i = 1'b0;
            @(negedge clk);
         end
         default:
         begin
            // Bypass on or off, status follows in IDLE
            model_bypass = (op_table[idx] == OP_BYPASS_ON);
            @(posedge clk);
            #1 bypass_icache_i = model_bypass;
            @(negedge clk);
            check_bit("cache_is_bypassed_o", model_bypass, cache_is_bypassed_o);
         end
      endcase
      if (!timed_out)
         check_bit("cache_is_flushed_o", model_flushed, cache_is_flushed_o);
   endtask

   task automatic reset_model_valid();
      for (int s = 0; s < NB_SETS; s++)
         model_valid[s] = '0;
      model_flushed = 1'b1;
   endtask

   initial
   begin : stimulus
      arst_n_i        = 1'b0;
      fetch_req_i     = 1'b0;
      fetch_addr_i    = '0;
      bypass_icache_i = 1'b0;
      flush_icache_i  = 1'b0;
      reset_model();
      build_table();
      repeat (5) @(posedge clk);
      #1 arst_n_i = 1'b1;
      // Port state right after reset
      @(negedge clk);
      check_bit("fetch_gnt_o", 1'b0, fetch_gnt_o);
      check_bit("fetch_rvalid_o", 1'b0, fetch_rvalid_o);
      check_bit("refill_req_o", 1'b0, refill_req_o);
      check_bit("cache_is_bypassed_o", 1'b0, cache_is_bypassed_o);
      check_bit("cache_is_flushed_o", 1'b1, cache_is_flushed_o);
      for (int i = 0; i < op_table.size(); i++)
      begin
         if (!timed_out)
            apply_entry(i);
      end
      $display("Errors %0d, refills %0d", error_count, refill_count);
      if (error_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== pri_icache.f ====
verilog/pri_icache_pkg.sv
verilog/pri_icache_data_bank.sv
verilog/pri_icache_tag_bank.sv
verilog/pri_icache_refill_port.sv
verilog/pri_icache_ctrl.sv
verilog/pri_icache.sv
tests/pri_icache_properties.sv
tests/tb_pri_icache.sv

// ==== Bender.yml ====
package:
  name: pri_icache

sources:
  - verilog/pri_icache_pkg.sv
  - verilog/pri_icache_data_bank.sv
  - verilog/pri_icache_tag_bank.sv
  - verilog/pri_icache_refill_port.sv
  - verilog/pri_icache_ctrl.sv
  - verilog/pri_icache.sv
  - target: test
    files:
      - tests/pri_icache_properties.sv
      - tests/tb_pri_icache.sv
